/* vlog.f */
+incdir+rtl
rtl/softusb_rx_pkg.sv
rtl/usb_line_if.sv
rtl/softusb_dpll.sv
rtl/softusb_eop_detect.sv
rtl/softusb_sync_fsm.sv
rtl/softusb_deserializer.sv
rtl/softusb_rx.sv
verification/usb_clk_gen.sv
verification/softusb_rx_assert.sv
verification/tb_softusb_rx.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_softusb_rx
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

/* verification/tb_softusb_rx.sv */
/*
 * USB receiver testbench
 * encodes random packets (sync, stuffing, NRZI, EOP) on the line
 * and checks the bytes against a queue of expected values
 */

`timescale 1ns/1ps
`include "softusb_rx_config.svh"

module tb_softusb_rx;

	localparam int FS_BIT = 4;	// cycles per bit
	localparam int LS_BIT = 32;
	localparam int PKT_BITS = 110;	// worst case per packet incl. gaps
	localparam longint WATCHDOG_NS = (16 * PKT_BITS * FS_BIT + 5 * PKT_BITS * LS_BIT) * 20
		+ 20000;

	logic usb_clk, rxreset;
	logic rx, rxp, rxm, low_speed;
	logic [7:0] rx_data;
	logic rx_valid, rx_active;

	integer seed = 32'h79c3;
	int value_errors = 0;
	int other_errors = 0;
	bit idle_watch = 1'b0;
	softusb_rx_pkg::rx_byte_t pkt [0:7];
	softusb_rx_pkg::rx_byte_t exp_q [$];

	usb_clk_gen u_clk (.usb_clk(usb_clk), .rxreset(rxreset));

	softusb_rx u_dut (
		.usb_clk(usb_clk), .rxreset(rxreset), .rx(rx), .rxp(rxp), .rxm(rxm),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_active(rx_active),
		.low_speed(low_speed)
	);

	task automatic check_byte(input softusb_rx_pkg::rx_byte_t exp,
		input softusb_rx_pkg::rx_byte_t act);
		if (act !== exp) begin
			value_errors++;
			$display("Fail t=%0t rx_data expected %h got %h", $time, exp, act);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("Fail t=%0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// one line level (or SE0) for a number of cycles
	task automatic hold_line(input logic lvl, input logic se0, input int cycles);
		repeat (cycles) begin
			@(posedge usb_clk);
			rx <= lvl ^ low_speed;
			rxp <= se0 ? 1'b0 : (lvl ^ low_speed);
			rxm <= se0 ? 1'b0 : ~(lvl ^ low_speed);
		end
	endtask

	task automatic switch_speed(input logic ls);
		@(posedge usb_clk);
		low_speed <= ls;
		rx <= ~ls;	// J on the new polarity
		rxp <= ~ls;
		rxm <= ls;
		hold_line(1'b1, 1'b0, 10 * (ls ? LS_BIT : FS_BIT));
	endtask

	// sync, stuffing and NRZI from J, then EOP and idle
	task automatic send_packet(input int nbytes, input bit corrupt);
		logic lvl_q [$];
		logic lvl;
		logic b;
		int ones;
		int bad_idx;
		int period;
		bit corrupted;
		lvl = 1'b1;
		ones = 0;
		bad_idx = -10;
		corrupted = 1'b0;
		period = low_speed ? LS_BIT : FS_BIT;
		for (int i = 0; i < 8 + nbytes * 8; i++) begin
			b = (i < 8) ? (i == 7) : pkt[(i - 8) / 8][(i - 8) % 8];
			if (!b)
				lvl = ~lvl;	// zero toggles the line
			lvl_q.push_back(lvl);
			ones = b ? ones + 1 : 0;
			if (i >= 8 && (i - 8) % 8 == 7 && !corrupted)
				exp_q.push_back(pkt[(i - 8) / 8]);
			if (ones == `SOFTUSB_STUFF_LIMIT) begin
				ones = 0;
				if (corrupt && !corrupted) begin
					corrupted = 1'b1;
					bad_idx = lvl_q.size();	// stuffed bit without a transition
				end else begin
					lvl = ~lvl;
				end
				lvl_q.push_back(lvl);
			end
		end
		@(negedge usb_clk);
		check_level("rx_active", 1'b0, rx_active);
		foreach (lvl_q[k]) begin
			hold_line(lvl_q[k], 1'b0, period);
			if (k == bad_idx + 1) begin
				@(negedge usb_clk);
				check_level("rx_active", 1'b0, rx_active);
			end
		end
		hold_line(lvl, 1'b1, 2 * period);
		hold_line(1'b1, 1'b0, 7 * period);
		@(negedge usb_clk);
		check_level("rx_active", 1'b0, rx_active);
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("%0d expected bytes never arrived by t=%0t", exp_q.size(), $time);
			exp_q.delete();
		end
	endtask

	task automatic fill_random(input int nbytes);
		for (int i = 0; i < nbytes; i++)
			pkt[i] = softusb_rx_pkg::rx_byte_t'($random(seed));
	endtask

	// byte monitor
	always @(negedge usb_clk) begin
		if (!rxreset && rx_valid) begin
			check_level("rx_active", 1'b1, rx_active);
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("unexpected byte %h received at t=%0t", rx_data, $time);
			end else begin
				check_byte(exp_q.pop_front(), rx_data);
			end
		end
		if (idle_watch)
			check_level("rx_active", 1'b0, rx_active);
	end

	initial begin
		int n;
		rx = 1'b1;
		rxp = 1'b1;
		rxm = 1'b0;
		low_speed = 1'b0;
		wait (rxreset == 1'b0);
		hold_line(1'b1, 1'b0, 20);
		for (int p = 0; p < 10; p++) begin
			n = 1 + ($unsigned($random(seed)) % 8);
			fill_random(n);
			send_packet(n, 1'b0);
		end
		// ones-heavy payloads
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < 6; i++)
				pkt[i] = ($random(seed) & 1) ? 8'hff : 8'h7e;
			send_packet(6, 1'b0);
		end
		pkt[0] = 8'h5a;
		pkt[1] = 8'hff;
		pkt[2] = 8'hff;
		pkt[3] = 8'hff;
		send_packet(4, 1'b1);
		// KJK then a long J
		@(posedge usb_clk);
		idle_watch = 1'b1;
		hold_line(1'b0, 1'b0, FS_BIT);
		hold_line(1'b1, 1'b0, FS_BIT);
		hold_line(1'b0, 1'b0, FS_BIT);
		hold_line(1'b1, 1'b0, 30 * FS_BIT);
		idle_watch = 1'b0;
		fill_random(5);
		send_packet(5, 1'b0);
		switch_speed(1'b1);
		for (int p = 0; p < 3; p++) begin
			n = 1 + ($unsigned($random(seed)) % 4);
			fill_random(n);
			send_packet(n, 1'b0);
		end
		$display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

/* verification/softusb_rx_assert.sv */
/*
 * receiver output assertions
 * strobe and level rules on rx_valid and rx_active
 */

`timescale 1ns/1ps

module softusb_rx_assert (
	input logic usb_clk,
	input logic rxreset,
	input logic rx_valid,
	input logic rx_active,
	input logic eop_detected
);

	// a byte strobe only inside a packet
	a_valid_in_packet: assert property (@(posedge usb_clk) disable iff (rxreset)
		rx_valid |-> rx_active)
		else $error("rx_valid outside rx_active");

	a_quiet_after_reset: assert property (@(posedge usb_clk)
		rxreset |=> !rx_valid)
		else $error("rx_valid right after reset");

	a_eop_ends_packet: assert property (@(posedge usb_clk) disable iff (rxreset)
		eop_detected |=> !rx_active)
		else $error("rx_active still high after eop");

endmodule

bind softusb_rx softusb_rx_assert u_assert (
	.usb_clk(usb_clk), .rxreset(rxreset), .rx_valid(rx_valid),
	.rx_active(rx_active), .eop_detected(line.eop_detected)
);

/* verification/usb_clk_gen.sv */
/*
 * testbench clock and reset
 * 20 ns usb_clk, rxreset held for two cycles
 */

`timescale 1ns/1ps

module usb_clk_gen (
	output logic usb_clk,
	output logic rxreset
);

	initial begin
		usb_clk = 1'b0;
		forever #10 usb_clk = ~usb_clk;
	end

	initial begin
		rxreset = 1'b1;
		repeat (2) @(posedge usb_clk);
		rxreset <= 1'b0;
	end

endmodule

/* rtl/softusb_rx.sv */
/*
 * USB 1.1 receiver
 * line polarity correction, SE0 decode and the clock recovery,
 * EOP, sync and deserializer blocks
 */

`timescale 1ns/1ps

module softusb_rx (
	input  logic usb_clk,
	input  logic rxreset,
	input  logic rx,
	input  logic rxp,
	input  logic rxm,
	output logic [7:0] rx_data,
	output logic rx_valid,
	output logic rx_active,
	input  logic low_speed
);

	usb_line_if line ();

	logic se0;
	logic start_rx;
	softusb_rx_pkg::rx_byte_t rx_byte;

	assign line.rx_corrected = rx ^ low_speed;	// low speed J is the other level
	assign line.low_speed = low_speed;
	assign se0 = ~rxp & ~rxm;
	assign rx_data = rx_byte;

	softusb_dpll u_dpll (
		.usb_clk(usb_clk), .rxreset(rxreset), .rx(rx), .line(line)
	);

	softusb_eop_detect u_eop (
		.usb_clk(usb_clk), .rxreset(rxreset), .se0(se0), .line(line)
	);

	softusb_sync_fsm u_sync (
		.usb_clk(usb_clk), .rxreset(rxreset), .rx_active(rx_active),
		.line(line), .start_rx(start_rx)
	);

	softusb_deserializer u_deser (
		.usb_clk(usb_clk), .rxreset(rxreset), .start_rx(start_rx), .line(line),
		.rx_data(rx_byte), .rx_valid(rx_valid), .rx_active(rx_active)
	);

endmodule

/* rtl/softusb_deserializer.sv */
/*
 * USB receive deserializer
 * NRZI decode, stuffed bit removal and LSB-first byte assembly;
 * owns rx_active and the rx_valid strobe
 */

`timescale 1ns/1ps
`include "softusb_rx_config.svh"

module softusb_deserializer (
	input  logic usb_clk,
	input  logic rxreset,
	input  logic start_rx,
	usb_line_if.deser line,
	output softusb_rx_pkg::rx_byte_t rx_data,
	output logic rx_valid,
	output logic rx_active
);

	logic [2:0] bitcount;
	logic [2:0] onecount;
	logic lastrx;		// line level at the previous sample
	logic rx_bit;

	assign rx_bit = (line.rx_corrected == lastrx);	// no change decodes as 1

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			rx_active <= 1'b0;
			rx_valid <= 1'b0;
			bitcount <= 3'd0;
			onecount <= 3'd0;
			lastrx <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (line.eop_detected) begin
				rx_active <= 1'b0;
			end else if (line.dpll_ce) begin
				if (rx_active) begin
					if (onecount == `SOFTUSB_STUFF_LIMIT) begin
						// stuffed zero, must toggle the line
						onecount <= 3'd0;
						if (rx_bit)
							rx_active <= 1'b0;	// bitstuff error
						lastrx <= ~lastrx;
					end else begin
						rx_data <= {rx_bit, rx_data[7:1]};
						onecount <= rx_bit ? onecount + 3'd1 : 3'd0;
						lastrx <= line.rx_corrected;
						rx_valid <= (bitcount == 3'd7);
						bitcount <= bitcount + 3'd1;
					end
				end else if (start_rx) begin
					rx_active <= 1'b1;
					bitcount <= 3'd0;
					onecount <= 3'd1;	// last sync K counts as a one
					lastrx <= 1'b0;
				end
			end
		end
	end

endmodule

/* rtl/softusb_sync_fsm.sv */
/*
 * USB sync pattern finder
 * follows KJKJKJ on line levels, then checks the two closing K bits
 * on the sample strobe and pulses start_rx; stalls return to idle
 */

`timescale 1ns/1ps
`include "softusb_rx_config.svh"

module softusb_sync_fsm (
	input  logic usb_clk,
	input  logic rxreset,
	input  logic rx_active,
	usb_line_if.sync line,
	output logic start_rx
);

	softusb_rx_pkg::fs_state_t fs_state;
	softusb_rx_pkg::fs_state_t fs_next_state;
	logic [5:0] fs_timeout_counter;
	logic fs_timeout;

	// counts cycles spent in one state
	always_ff @(posedge usb_clk) begin
		if (rxreset | line.eop_detected) begin
			fs_timeout_counter <= 6'd0;
			fs_timeout <= 1'b0;
		end else begin
			if ((fs_state != fs_next_state) | (fs_state == softusb_rx_pkg::FS_IDLE))
				fs_timeout_counter <= 6'd0;
			else
				fs_timeout_counter <= fs_timeout_counter + 6'd1;
			if (line.low_speed)
				fs_timeout <= (fs_timeout_counter == `SOFTUSB_LS_TIMEOUT);
			else
				fs_timeout <= (fs_timeout_counter == `SOFTUSB_FS_TIMEOUT);
		end
	end

	always_ff @(posedge usb_clk) begin
		if (rxreset | line.eop_detected | fs_timeout)
			fs_state <= softusb_rx_pkg::FS_IDLE;
		else
			fs_state <= fs_next_state;
	end

	always_comb begin
		start_rx = 1'b0;
		fs_next_state = fs_state;
		case (fs_state)
			softusb_rx_pkg::FS_IDLE:
				if (~line.rx_corrected & ~rx_active)	// first K, not mid-packet
					fs_next_state = softusb_rx_pkg::K1;
			softusb_rx_pkg::K1: if (line.rx_corrected) fs_next_state = softusb_rx_pkg::J1;
			softusb_rx_pkg::J1: if (~line.rx_corrected) fs_next_state = softusb_rx_pkg::K2;
			softusb_rx_pkg::K2: if (line.rx_corrected) fs_next_state = softusb_rx_pkg::J2;
			softusb_rx_pkg::J2: if (~line.rx_corrected) fs_next_state = softusb_rx_pkg::K3;
			softusb_rx_pkg::K3: if (line.rx_corrected) fs_next_state = softusb_rx_pkg::J3;
			softusb_rx_pkg::J3: if (~line.rx_corrected) fs_next_state = softusb_rx_pkg::K4;
			softusb_rx_pkg::K4:
				if (line.dpll_ce) begin
					// second K of the closing pair must be sampled
					if (~line.rx_corrected)
						fs_next_state = softusb_rx_pkg::K5;
					else
						fs_next_state = softusb_rx_pkg::FS_IDLE;
				end
			softusb_rx_pkg::K5:
				if (line.dpll_ce) begin
					start_rx = ~line.rx_corrected;
					fs_next_state = softusb_rx_pkg::FS_IDLE;
				end
			default: fs_next_state = softusb_rx_pkg::FS_IDLE;
		endcase
	end

endmodule

/* rtl/softusb_eop_detect.sv */
/*
 * USB end-of-packet detector
 * flags EOP when J follows three or more SE0 cycles
 */

`timescale 1ns/1ps

module softusb_eop_detect (
	input  logic usb_clk,
	input  logic rxreset,
	input  logic se0,
	usb_line_if.eop line
);

	softusb_rx_pkg::eop_state_t eop_state;
	softusb_rx_pkg::eop_state_t eop_next_state;

	always_ff @(posedge usb_clk) begin
		if (rxreset)
			eop_state <= softusb_rx_pkg::IDLE;
		else
			eop_state <= eop_next_state;
	end

	always_comb begin
		line.eop_detected = 1'b0;
		eop_next_state = softusb_rx_pkg::IDLE;
		case (eop_state)
			softusb_rx_pkg::IDLE:
				if (se0) eop_next_state = softusb_rx_pkg::SE0_1;
			softusb_rx_pkg::SE0_1:
				if (se0) eop_next_state = softusb_rx_pkg::SE0_2;
			softusb_rx_pkg::SE0_2:
				if (se0) eop_next_state = softusb_rx_pkg::SE0_3;
			softusb_rx_pkg::SE0_3: begin
				if (se0)
					eop_next_state = softusb_rx_pkg::SE0_3;	// stay while SE0 lasts
				else if (line.rx_corrected)
					line.eop_detected = 1'b1;
				else
					eop_next_state = softusb_rx_pkg::WAIT_J;	// allow one cycle of skew
			end
			softusb_rx_pkg::WAIT_J:
				line.eop_detected = line.rx_corrected;
			default: eop_next_state = softusb_rx_pkg::IDLE;
		endcase
	end

endmodule

/* rtl/softusb_dpll.sv */
/*
 * USB bit clock recovery
 * restarts a cycle counter on every line edge and raises the
 * sample enable near the middle of each bit
 */

`timescale 1ns/1ps
`include "softusb_rx_config.svh"

module softusb_dpll (
	input  logic usb_clk,
	input  logic rxreset,
	input  logic rx,
	usb_line_if.dpll line
);

	logic rx_r;
	logic transition;
	logic [4:0] dpll_counter;

	always_ff @(posedge usb_clk)
		rx_r <= rx;

	assign transition = (rx != rx_r);	// raw line, polarity does not matter

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			dpll_counter <= 5'd0;
			line.dpll_ce <= 1'b0;
		end else begin
			if (transition)
				dpll_counter <= 5'd0;
			else
				dpll_counter <= dpll_counter + 5'd1;
			// full speed has 4 cycles per bit, resync on each edge
			if (line.low_speed)
				line.dpll_ce <= (dpll_counter == `SOFTUSB_LS_SAMPLE);
			else
				line.dpll_ce <= transition | (dpll_counter[1:0] == 2'd3);
		end
	end

endmodule

/* rtl/usb_line_if.sv */
/*
 * USB receiver line bundle
 * corrected line level, speed select and the timing strobes
 * shared by the receiver blocks
 */

`timescale 1ns/1ps

interface usb_line_if;

	logic rx_corrected;	// J reads as 1 at both speeds
	logic low_speed;
	logic dpll_ce;		// bit sample strobe
	logic eop_detected;

	modport dpll (output dpll_ce, input low_speed);

	modport eop (output eop_detected, input rx_corrected);

	modport sync (input rx_corrected, input low_speed, input dpll_ce,
		input eop_detected);

	modport deser (input rx_corrected, input low_speed, input dpll_ce,
		input eop_detected);

endinterface

/* rtl/softusb_rx_pkg.sv */
/*
 * USB receiver types
 * FSM state encodings and the received byte type
 */

package softusb_rx_pkg;

	typedef logic [7:0] rx_byte_t;

	// end-of-packet detector, counts SE0 cycles then looks for J
	typedef enum logic [2:0] {
		IDLE, SE0_1, SE0_2, SE0_3, WAIT_J
	} eop_state_t;

	// sync finder, one state per line level of KJKJKJKK
	typedef enum logic [3:0] {
		FS_IDLE, K1, J1, K2, J2, K3, J3, K4, K5
	} fs_state_t;

endpackage

/* rtl/softusb_rx_config.svh */
/*
 * USB receiver constants
 * stall limits, low-speed sample point and bit stuffing run
 */

`ifndef SOFTUSB_RX_CONFIG_SVH
`define SOFTUSB_RX_CONFIG_SVH

// sync finder stall limits in usb_clk cycles, minus one
`define SOFTUSB_FS_TIMEOUT	6'd7
`define SOFTUSB_LS_TIMEOUT	6'd63

`define SOFTUSB_LS_SAMPLE	5'd13	// roughly mid bit at 32 cycles per bit

`define SOFTUSB_STUFF_LIMIT	3'd6	// ones before a stuffed zero

`endif
